// File: rtl/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // Bus geometry
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int OFF_W = 4;

    // Queue depth, equal to the credits the master holds after reset
    localparam int REQ_CREDITS = 2;

    // Address map
    localparam logic [ADDR_W-1:0] CONF_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] SPI_BASE = 16'h0100;
    localparam logic [ADDR_W-1:0] REGION_MASK = 16'hFF00;

    localparam int KEY_W = 5;
    localparam int SPI_DIV_W = 8;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } bus_rsp_t;

    // Single-cycle access seen by a slave
    typedef struct packed {
        logic              write;
        logic [OFF_W-1:0]  offset;
        logic [DATA_W-1:0] wdata;
    } slave_req_t;

    typedef enum logic [1:0] {TGT_CONF, TGT_SPI, TGT_NONE} target_e;

    // Word offsets inside the configuration block
    typedef enum logic [OFF_W-1:0] {
        CR_LED      = 4'h0,
        CR_SEG_CSN  = 4'h1,
        CR_SEG_AG   = 4'h2,
        CR_IRQ_MASK = 4'h4,
        CR_IRQ_STAT = 4'h5,
        CR_KEYS     = 4'h6
    } conf_reg_e;

    typedef enum logic [OFF_W-1:0] {SR_CTRL = 4'h0, SR_STATUS = 4'h1, SR_DATA = 4'h2} spi_reg_e;

    typedef enum logic [1:0] {SPI_IDLE, SPI_LOW, SPI_HIGH, SPI_END} spi_state_e;

endpackage

`default_nettype wire

// File: rtl/spi_shifter.sv
`default_nettype none
`timescale 1ns/1ps

module spi_shifter (
    input  wire                          c1_clk0,
    input  wire                          reset_i,
    input  wire                          start_i,
    input  wire [7:0]                    tx_byte_i,
    input  wire [soc_pkg::SPI_DIV_W-1:0] div_i,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [7:0]                   rx_byte_o,
    output logic                         sck_o,
    output logic                         cs_n_o,
    output logic                         mosi_o,
    input  wire                          miso_i
);

    soc_pkg::spi_state_e           state_q;
    logic [soc_pkg::SPI_DIV_W-1:0] div_cnt_q;
    logic [2:0]                    bit_cnt_q;
    logic [7:0]                    tx_sh_q;
    logic [7:0]                    rx_sh_q;

    assign busy_o = (state_q != soc_pkg::SPI_IDLE);
    assign done_o = (state_q == soc_pkg::SPI_END);
    assign mosi_o = tx_sh_q[7];

    always_ff @(posedge c1_clk0)
    begin
        if (reset_i)
        begin
            state_q   <= soc_pkg::SPI_IDLE;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            sck_o     <= 1'b0;
            cs_n_o    <= 1'b1;
        end
        else
        begin
            case (state_q)
                soc_pkg::SPI_IDLE:
                    if (start_i)
                    begin
                        state_q   <= soc_pkg::SPI_LOW;
                        div_cnt_q <= div_i;
                        bit_cnt_q <= '0;
                        cs_n_o    <= 1'b0;
                    end
                soc_pkg::SPI_LOW:
                    if (div_cnt_q == '0)
                    begin
                        state_q   <= soc_pkg::SPI_HIGH;
                        div_cnt_q <= div_i;
                        sck_o     <= 1'b1;
                    end
                    else
                        div_cnt_q <= div_cnt_q - 1'b1;
                soc_pkg::SPI_HIGH:
                    if (div_cnt_q == '0)
                    begin
                        // Last high phase hands over to the finish cycle
                        state_q   <= (bit_cnt_q == 3'd7) ? soc_pkg::SPI_END : soc_pkg::SPI_LOW;
                        div_cnt_q <= div_i;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        sck_o     <= 1'b0;
                    end
                    else
                        div_cnt_q <= div_cnt_q - 1'b1;
                default:
                begin
                    state_q <= soc_pkg::SPI_IDLE;
                    cs_n_o  <= 1'b1;
                end
            endcase
        end
    end

    // Shift registers, MSB first
    always_ff @(posedge c1_clk0)
    begin
        if (state_q == soc_pkg::SPI_IDLE && start_i)
            tx_sh_q <= tx_byte_i;
        else if (state_q == soc_pkg::SPI_HIGH && div_cnt_q == '0)
            tx_sh_q <= {tx_sh_q[6:0], 1'b0};
        if (state_q == soc_pkg::SPI_LOW && div_cnt_q == '0)
            rx_sh_q <= {rx_sh_q[6:0], miso_i};
        if (state_q == soc_pkg::SPI_END)
            rx_byte_o <= rx_sh_q;
    end

endmodule

`default_nettype wire

// File: rtl/spi_regs.sv
`default_nettype none
`timescale 1ns/1ps

module spi_regs (
    input  wire                        c1_clk0,
    input  wire                        reset_i,
    input  wire                        valid_i,
    input  wire soc_pkg::slave_req_t   req_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o,
    output logic                       ready_o,
    output logic                       spi_irq_o,
    output logic                       spi_sck_o,
    output logic                       spi_cs_n_o,
    output logic                       spi_mosi_o,
    input  wire                        spi_miso_i
);

    logic [soc_pkg::SPI_DIV_W-1:0] div_q;
    logic                          irq_en_q;
    logic                          done_q;
    logic                          start_q;
    logic [7:0]                    tx_q;
    logic [7:0]                    rx_byte;
    logic                          shift_busy;
    logic                          shift_done;
    logic                          busy;

    // Busy already in the cycle the start is pending
    assign busy = shift_busy | start_q;
    assign ready_o = !(busy && req_i.write && req_i.offset == soc_pkg::SR_DATA);
    assign spi_irq_o = done_q & irq_en_q;

    always_ff @(posedge c1_clk0)
    begin
        if (reset_i)
        begin
            div_q    <= '0;
            irq_en_q <= 1'b0;
            done_q   <= 1'b0;
            start_q  <= 1'b0;
        end
        else
        begin
            start_q <= valid_i && req_i.write && req_i.offset == soc_pkg::SR_DATA;
            if (valid_i && req_i.write && req_i.offset == soc_pkg::SR_CTRL)
            begin
                div_q    <= req_i.wdata[soc_pkg::SPI_DIV_W-1:0];
                irq_en_q <= req_i.wdata[8];
            end
            if (shift_done)
                done_q <= 1'b1;
            else if (valid_i && req_i.write && req_i.offset == soc_pkg::SR_STATUS &&
                     req_i.wdata[1])
                done_q <= 1'b0;
        end
    end

    always_ff @(posedge c1_clk0)
    begin
        if (valid_i && req_i.write && req_i.offset == soc_pkg::SR_DATA)
            tx_q <= req_i.wdata[7:0];
    end

    always_comb
    begin
        rdata_o = '0;
        case (req_i.offset)
            soc_pkg::SR_CTRL:   rdata_o[8:0] = {irq_en_q, div_q};
            soc_pkg::SR_STATUS: rdata_o[15:0] = {rx_byte, 6'b0, done_q, busy};
            soc_pkg::SR_DATA:   rdata_o[7:0] = rx_byte;
            default:            rdata_o = '0;
        endcase
    end

    spi_shifter spi_shifter_inst (
        .c1_clk0   (c1_clk0),
        .reset_i   (reset_i),
        .start_i   (start_q),
        .tx_byte_i (tx_q),
        .div_i     (div_q),
        .busy_o    (shift_busy),
        .done_o    (shift_done),
        .rx_byte_o (rx_byte),
        .sck_o     (spi_sck_o),
        .cs_n_o    (spi_cs_n_o),
        .mosi_o    (spi_mosi_o),
        .miso_i    (spi_miso_i)
    );

endmodule

`default_nettype wire

// File: rtl/conf_regs.sv
`default_nettype none
`timescale 1ns/1ps

module conf_regs (
    input  wire                        c1_clk0,
    input  wire                        reset_i,
    input  wire                        valid_i,
    input  wire soc_pkg::slave_req_t   req_i,
    output logic [soc_pkg::DATA_W-1:0] rdata_o,
    input  wire [soc_pkg::KEY_W-1:0]   key_i,
    input  wire                        spi_irq_i,
    output logic [15:0]                led_o,
    output logic [7:0]                 seg_csn_o,
    output logic [7:0]                 seg_a_g_o,
    output logic                       irq_o
);

    logic [soc_pkg::KEY_W-1:0] key_meta_q;
    logic [soc_pkg::KEY_W-1:0] key_sync_q;
    logic [soc_pkg::KEY_W-1:0] keys;
    logic [1:0]                irq_mask_q;
    logic [1:0]                irq_stat;
    logic                      key_pend;

    // Key 0 on the board is active low
    assign keys = {key_sync_q[soc_pkg::KEY_W-1:1], ~key_sync_q[0]};
    assign key_pend = keys[4] | keys[3] | keys[2] | keys[0];
    assign irq_stat = {spi_irq_i, key_pend};
    assign irq_o = |(irq_stat & irq_mask_q);

    always_ff @(posedge c1_clk0)
    begin
        if (reset_i)
        begin
            led_o      <= '0;
            seg_csn_o  <= '1;
            seg_a_g_o  <= '0;
            irq_mask_q <= '0;
            key_meta_q <= '0;
            key_sync_q <= '0;
        end
        else
        begin
            key_meta_q <= key_i;
            key_sync_q <= key_meta_q;
            if (valid_i && req_i.write)
            begin
                case (req_i.offset)
                    soc_pkg::CR_LED:      led_o      <= req_i.wdata[15:0];
                    soc_pkg::CR_SEG_CSN:  seg_csn_o  <= req_i.wdata[7:0];
                    soc_pkg::CR_SEG_AG:   seg_a_g_o  <= req_i.wdata[7:0];
                    soc_pkg::CR_IRQ_MASK: irq_mask_q <= req_i.wdata[1:0];
                    default:              ;
                endcase
            end
        end
    end

    // Read data is valid in the access cycle
    always_comb
    begin
        rdata_o = '0;
        case (req_i.offset)
            soc_pkg::CR_LED:      rdata_o[15:0] = led_o;
            soc_pkg::CR_SEG_CSN:  rdata_o[7:0]  = seg_csn_o;
            soc_pkg::CR_SEG_AG:   rdata_o[7:0]  = seg_a_g_o;
            soc_pkg::CR_KEYS:     rdata_o[soc_pkg::KEY_W-1:0] = keys;
            soc_pkg::CR_IRQ_MASK: rdata_o[1:0]  = irq_mask_q;
            soc_pkg::CR_IRQ_STAT: rdata_o[1:0]  = irq_stat;
            default:              rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/bus_fabric.sv
`default_nettype none
`timescale 1ns/1ps

module bus_fabric (
    input  wire                       c1_clk0,
    input  wire                       reset_i,
    input  wire                       req_valid_i,
    input  wire soc_pkg::bus_req_t    req_i,
    output logic                      credit_o,
    output logic                      rsp_valid_o,
    output soc_pkg::bus_rsp_t         rsp_o,
    output logic                      conf_valid_o,
    output logic                      spi_valid_o,
    output soc_pkg::slave_req_t       slave_req_o,
    input  wire [soc_pkg::DATA_W-1:0] conf_rdata_i,
    input  wire [soc_pkg::DATA_W-1:0] spi_rdata_i,
    input  wire                       spi_ready_i
);

    soc_pkg::bus_req_t queue_mem [soc_pkg::REQ_CREDITS];
    logic [$clog2(soc_pkg::REQ_CREDITS)-1:0]   wr_ptr_q;
    logic [$clog2(soc_pkg::REQ_CREDITS)-1:0]   rd_ptr_q;
    logic [$clog2(soc_pkg::REQ_CREDITS+1)-1:0] count_q;
    soc_pkg::bus_req_t head;
    soc_pkg::target_e  target;
    soc_pkg::bus_rsp_t rsp_d;
    logic              window_ok;
    logic              pop;
    logic              pop_q;

    assign head = queue_mem[rd_ptr_q];

    // Each block decodes a 64-byte window of word registers
    assign window_ok = (head.addr[7:6] == 2'b00);

    always_comb
    begin
        target = soc_pkg::TGT_NONE;
        if ((head.addr & soc_pkg::REGION_MASK) == soc_pkg::CONF_BASE && window_ok &&
            slave_req_o.offset inside {soc_pkg::CR_LED, soc_pkg::CR_SEG_CSN,
            soc_pkg::CR_SEG_AG, soc_pkg::CR_KEYS, soc_pkg::CR_IRQ_MASK,
            soc_pkg::CR_IRQ_STAT})
            target = soc_pkg::TGT_CONF;
        else if ((head.addr & soc_pkg::REGION_MASK) == soc_pkg::SPI_BASE && window_ok &&
            slave_req_o.offset inside {soc_pkg::SR_CTRL, soc_pkg::SR_STATUS, soc_pkg::SR_DATA})
            target = soc_pkg::TGT_SPI;
    end

    assign slave_req_o.write  = head.write;
    assign slave_req_o.offset = head.addr[soc_pkg::OFF_W+1:2];
    assign slave_req_o.wdata  = head.wdata;

    // Head waits while the SPI block cannot take it
    assign pop = (count_q != '0) && !(target == soc_pkg::TGT_SPI && !spi_ready_i);
    assign conf_valid_o = pop && (target == soc_pkg::TGT_CONF);
    assign spi_valid_o  = pop && (target == soc_pkg::TGT_SPI);

    always_comb
    begin
        rsp_d.rdata = '0;
        rsp_d.err   = 1'b0;
        case (target)
            soc_pkg::TGT_CONF: rsp_d.rdata = conf_rdata_i;
            soc_pkg::TGT_SPI:  rsp_d.rdata = spi_rdata_i;
            default:           rsp_d.err   = 1'b1;
        endcase
        if (head.write)
            rsp_d.rdata = '0;
    end

    always_ff @(posedge c1_clk0)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            pop_q    <= 1'b0;
        end
        else
        begin
            if (req_valid_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + req_valid_i - pop;
            pop_q   <= pop;
        end
    end

    always_ff @(posedge c1_clk0)
    begin
        if (req_valid_i)
            queue_mem[wr_ptr_q] <= req_i;
        if (pop)
            rsp_o <= rsp_d;
    end

    // One credit and one response per popped request
    assign credit_o    = pop_q;
    assign rsp_valid_o = pop_q;

endmodule

`default_nettype wire

// File: rtl/soc_top.sv
`default_nettype none
`timescale 1ns/1ps

module soc_top (
    input  wire                       c1_clk0,
    input  wire                       reset_i,
    input  wire                       req_valid_i,
    input  wire soc_pkg::bus_req_t    req_i,
    output logic                      credit_o,
    output logic                      rsp_valid_o,
    output soc_pkg::bus_rsp_t         rsp_o,
    input  wire [soc_pkg::KEY_W-1:0]  key_i,
    output logic [15:0]               led_o,
    output logic [7:0]                seg_csn_o,
    output logic [7:0]                seg_a_g_o,
    output logic                      irq_o,
    output logic                      spi_sck_o,
    output logic                      spi_cs_n_o,
    output logic                      spi_mosi_o,
    input  wire                       spi_miso_i
);

    soc_pkg::slave_req_t         slave_req;
    logic                        conf_valid;
    logic                        spi_valid;
    logic [soc_pkg::DATA_W-1:0]  conf_rdata;
    logic [soc_pkg::DATA_W-1:0]  spi_rdata;
    logic                        spi_ready;
    logic                        spi_irq;

    bus_fabric bus_fabric_inst (
        .c1_clk0      (c1_clk0),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .credit_o     (credit_o),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o),
        .conf_valid_o (conf_valid),
        .spi_valid_o  (spi_valid),
        .slave_req_o  (slave_req),
        .conf_rdata_i (conf_rdata),
        .spi_rdata_i  (spi_rdata),
        .spi_ready_i  (spi_ready)
    );

    // Board-facing registers and interrupt gathering
    conf_regs conf_regs_inst (
        .c1_clk0   (c1_clk0),
        .reset_i   (reset_i),
        .valid_i   (conf_valid),
        .req_i     (slave_req),
        .rdata_o   (conf_rdata),
        .key_i     (key_i),
        .spi_irq_i (spi_irq),
        .led_o     (led_o),
        .seg_csn_o (seg_csn_o),
        .seg_a_g_o (seg_a_g_o),
        .irq_o     (irq_o)
    );

    spi_regs spi_regs_inst (
        .c1_clk0    (c1_clk0),
        .reset_i    (reset_i),
        .valid_i    (spi_valid),
        .req_i      (slave_req),
        .rdata_o    (spi_rdata),
        .ready_o    (spi_ready),
        .spi_irq_o  (spi_irq),
        .spi_sck_o  (spi_sck_o),
        .spi_cs_n_o (spi_cs_n_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_miso_i (spi_miso_i)
    );

endmodule

`default_nettype wire

// File: verification/soc_tb.sv
`default_nettype none
`timescale 1ns/1ps

module soc_tb;

    localparam int ACCESS_CYCLES = 6;
    localparam int XFER_CYCLES = 16 * 4 + 1;
    localparam int DRAIN_LIMIT = 8 * XFER_CYCLES;
    localparam int POLL_LIMIT = 64;
    // Worst case of each test added up, then doubled
    localparam int CYCLE_LIMIT = 2 * (10 + 12 * ACCESS_CYCLES + 6 * (8 + 3 * ACCESS_CYCLES)
        + 5 * (XFER_CYCLES + 8 * ACCESS_CYCLES) + 4 * XFER_CYCLES + 12 * ACCESS_CYCLES
        + 12 * ACCESS_CYCLES);

    // One outstanding request as the model expects its response
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] rdata;
        logic        err;
        logic        chk;
    } exp_t;

    logic                      c1_clk0;
    logic                      reset_i;
    logic                      req_valid;
    soc_pkg::bus_req_t         req;
    logic                      credit;
    logic                      rsp_valid;
    soc_pkg::bus_rsp_t         rsp;
    logic [soc_pkg::KEY_W-1:0] key;
    logic [15:0]               led;
    logic [7:0]                seg_csn;
    logic [7:0]                seg_a_g;
    logic                      irq;
    logic                      spi_sck;
    logic                      spi_cs_n;
    logic                      spi_mosi;

    exp_t        exp_q[$];
    exp_t        rsp_head;
    int          credits;
    int          errors;
    int          checks;
    int          cycles;
    int          sck_rises;
    logic        sck_last;
    logic [31:0] last_rdata;
    logic [15:0] led_m;
    logic [7:0]  seg_csn_m;
    logic [7:0]  seg_ag_m;

    // MISO looped back to MOSI
    soc_top soc_top_inst (
        .c1_clk0     (c1_clk0),
        .reset_i     (reset_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .credit_o    (credit),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .key_i       (key),
        .led_o       (led),
        .seg_csn_o   (seg_csn),
        .seg_a_g_o   (seg_a_g),
        .irq_o       (irq),
        .spi_sck_o   (spi_sck),
        .spi_cs_n_o  (spi_cs_n),
        .spi_mosi_o  (spi_mosi),
        .spi_miso_i  (spi_mosi)
    );

    initial
    begin
        c1_clk0 = 1'b0;
        forever
            #20 c1_clk0 = ~c1_clk0;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge c1_clk0);
            cycles = cycles + 1;
        end
        $display("Run stopped at the limit of %0d cycles before all tests ended", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks = checks + 1;
        assert (actual === expected)
        else
        begin
            errors = errors + 1;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected,
                     actual);
        end
    endtask

    // Credits come back and responses are compared mid-cycle
    always @(negedge c1_clk0)
    begin
        if (!reset_i)
        begin
            if (spi_sck && !sck_last)
                sck_rises = sck_rises + 1;
            sck_last = spi_sck;
            if (credit)
            begin
                credits = credits + 1;
                assert (credits <= soc_pkg::REQ_CREDITS)
                else
                begin
                    errors = errors + 1;
                    $display("Credit returned at %0t while all %0d credits were held", $time,
                             soc_pkg::REQ_CREDITS);
                end
            end
            if (rsp_valid)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    errors = errors + 1;
                    $display("Response at %0t with no request outstanding", $time);
                end
                if (exp_q.size() != 0)
                begin
                    rsp_head = exp_q.pop_front();
                    last_rdata = rsp.rdata;
                    check_value($sformatf("rsp_o.err (addr %h)", rsp_head.addr),
                                rsp_head.err, rsp.err);
                    if (rsp_head.chk)
                        check_value($sformatf("rsp_o.rdata (addr %h)", rsp_head.addr),
                                    rsp_head.rdata, rsp.rdata);
                end
            end
        end
    end

    function automatic logic [15:0] conf_addr(input logic [3:0] off);
        return soc_pkg::CONF_BASE | {10'b0, off, 2'b00};
    endfunction

    function automatic logic [15:0] spi_addr(input logic [3:0] off);
        return soc_pkg::SPI_BASE | {10'b0, off, 2'b00};
    endfunction

    // Valid stays high until the next send or drain
    task automatic send(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                        input logic [31:0] exp_rdata, input logic exp_err, input logic chk);
        @(posedge c1_clk0);
        req_valid <= 1'b0;
        while (credits == 0)
            @(posedge c1_clk0);
        req_valid <= 1'b1;
        req <= {wr, addr, wdata};
        credits = credits - 1;
        exp_q.push_back({addr, exp_rdata, exp_err, chk});
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        send(1'b1, addr, data, 32'h0, 1'b0, 1'b1);
    endtask

    task automatic read_expect(input logic [15:0] addr, input logic [31:0] expected);
        send(1'b0, addr, 32'h0, expected, 1'b0, 1'b1);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge c1_clk0);
        req_valid <= 1'b0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
        begin
            @(posedge c1_clk0);
            waited = waited + 1;
        end
        assert (exp_q.size() == 0)
        else
        begin
            errors = errors + 1;
            $display("No response for %0d request(s) after %0d cycles", exp_q.size(), waited);
            exp_q.delete();
        end
    endtask

    task automatic wait_spi_idle();
        int polls;
        polls = 0;
        last_rdata = 32'h1;
        while (last_rdata[0] && polls < POLL_LIMIT)
        begin
            send(1'b0, spi_addr(soc_pkg::SR_STATUS), 32'h0, 32'h0, 1'b0, 1'b0);
            drain();
            polls = polls + 1;
        end
        assert (!last_rdata[0])
        else
        begin
            errors = errors + 1;
            $display("SPI shifter still busy after %0d status polls", POLL_LIMIT);
        end
    endtask

    task automatic report(input string name, input int err_before);
        $display("%-20s done, %0d error(s)", name, errors - err_before);
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        @(negedge c1_clk0);
        check_value("led_o", 32'h0, led);
        check_value("seg_csn_o", 32'hFF, seg_csn);
        check_value("irq_o", 32'h0, irq);
        check_value("spi_sck_o", 32'h0, spi_sck);
        check_value("credit_o", 32'h0, credit);
        check_value("rsp_valid_o", 32'h0, rsp_valid);
        check_value("spi_cs_n_o", 32'h1, spi_cs_n);
        report("reset values", e0);
    endtask

    task automatic board_registers();
        int          e0;
        logic [31:0] data;
        logic [31:0] mask;
        logic [3:0]  off;
        e0 = errors;
        repeat (6)
        begin
            data = $urandom;
            case ($urandom % 3)
                0:
                begin
                    off = soc_pkg::CR_LED;
                    mask = 32'hFFFF;
                    led_m = data[15:0];
                end
                1:
                begin
                    off = soc_pkg::CR_SEG_CSN;
                    mask = 32'hFF;
                    seg_csn_m = data[7:0];
                end
                default:
                begin
                    off = soc_pkg::CR_SEG_AG;
                    mask = 32'hFF;
                    seg_ag_m = data[7:0];
                end
            endcase
            write_reg(conf_addr(off), data);
            read_expect(conf_addr(off), data & mask);
        end
        drain();
        @(negedge c1_clk0);
        check_value("led_o", led_m, led);
        check_value("seg_csn_o", seg_csn_m, seg_csn);
        check_value("seg_a_g_o", seg_ag_m, seg_a_g);
        report("board registers", e0);
    endtask

    task automatic keys_and_irq();
        int          e0;
        logic [31:0] rnd;
        logic [4:0]  shown;
        logic        pend;
        e0 = errors;
        repeat (6)
        begin
            rnd = $urandom;
            @(posedge c1_clk0);
            key <= rnd[4:0];
            // Past the two-flop synchronizer
            repeat (3)
                @(posedge c1_clk0);
            shown = rnd[4:0] ^ 5'b00001;
            pend = shown[4] | shown[3] | shown[2] | shown[0];
            write_reg(conf_addr(soc_pkg::CR_IRQ_MASK), {30'b0, rnd[9:8]});
            read_expect(conf_addr(soc_pkg::CR_KEYS), {27'b0, shown});
            read_expect(conf_addr(soc_pkg::CR_IRQ_STAT), {30'b0, 1'b0, pend});
            drain();
            @(negedge c1_clk0);
            check_value("irq_o", pend & rnd[8], irq);
        end
        report("keys and interrupt", e0);
    endtask

    task automatic spi_loopback();
        int          e0;
        int          rises0;
        logic [31:0] rnd;
        logic [7:0]  tx;
        e0 = errors;
        repeat (5)
        begin
            rnd = $urandom;
            tx = rnd[7:0];
            // Only the SPI interrupt unmasked
            write_reg(conf_addr(soc_pkg::CR_IRQ_MASK), 32'h2);
            write_reg(spi_addr(soc_pkg::SR_CTRL), {23'b0, 1'b1, 6'b0, rnd[9:8]});
            rises0 = sck_rises;
            write_reg(spi_addr(soc_pkg::SR_DATA), {24'b0, tx});
            drain();
            @(negedge c1_clk0);
            check_value("spi_cs_n_o", 32'h0, spi_cs_n);
            wait_spi_idle();
            check_value("spi_sck_o rising edges", 32'd8, sck_rises - rises0);
            check_value("SR_STATUS rx byte", tx, last_rdata[15:8]);
            check_value("SR_STATUS done", 32'h1, last_rdata[1]);
            @(negedge c1_clk0);
            check_value("irq_o", 32'h1, irq);
            write_reg(spi_addr(soc_pkg::SR_STATUS), 32'h2);
            read_expect(spi_addr(soc_pkg::SR_STATUS), {16'b0, tx, 8'h00});
            drain();
            @(negedge c1_clk0);
            check_value("irq_o", 32'h0, irq);
            check_value("spi_cs_n_o", 32'h1, spi_cs_n);
        end
        report("SPI loopback", e0);
    endtask

    task automatic credits_and_order();
        int          e0;
        logic [31:0] rnd;
        logic [31:0] ctrl;
        logic [7:0]  tx;
        e0 = errors;
        rnd = $urandom;
        ctrl = {31'b0, rnd[0]};
        write_reg(spi_addr(soc_pkg::SR_CTRL), ctrl);
        // Data writes stall behind a busy shifter and fill the queue
        for (int i = 0; i < 4; i++)
        begin
            rnd = $urandom;
            tx = rnd[7:0];
            write_reg(spi_addr(soc_pkg::SR_DATA), {24'b0, tx});
            read_expect(spi_addr(soc_pkg::SR_CTRL), ctrl);
            read_expect(conf_addr(soc_pkg::CR_LED), {16'b0, led_m});
        end
        drain();
        check_value("returned credits", soc_pkg::REQ_CREDITS, credits);
        wait_spi_idle();
        check_value("SR_STATUS rx byte", tx, last_rdata[15:8]);
        write_reg(spi_addr(soc_pkg::SR_STATUS), 32'h2);
        drain();
        report("credits and order", e0);
    endtask

    task automatic unmapped_access();
        int          e0;
        logic [31:0] rnd;
        logic [15:0] addr;
        logic [7:0]  upper;
        e0 = errors;
        repeat (12)
        begin
            rnd = $urandom;
            upper = (rnd[15:8] < 8'h02) ? rnd[15:8] + 8'h02 : rnd[15:8];
            case (rnd[1:0])
                2'd0:    addr = {upper, rnd[7:0]};
                2'd1:    addr = conf_addr(rnd[20] ? 4'd3 : 4'd7 + rnd[19:16] % 4'd9);
                default: addr = spi_addr(4'd3 + rnd[19:16] % 4'd13);
            endcase
            send(rnd[31], addr, $urandom, 32'h0, 1'b1, 1'b1);
        end
        drain();
        report("unmapped access", e0);
    endtask

    initial
    begin
        reset_i = 1'b1;
        req_valid = 1'b0;
        req = '0;
        key = '0;
        credits = soc_pkg::REQ_CREDITS;
        errors = 0;
        checks = 0;
        sck_rises = 0;
        sck_last = 1'b0;
        last_rdata = '0;
        led_m = '0;
        seg_csn_m = '1;
        seg_ag_m = '0;
        void'($urandom(32'h1e13));
        repeat (2)
            @(posedge c1_clk0);
        reset_i <= 1'b0;
        reset_values();
        board_registers();
        keys_and_irq();
        spi_loopback();
        credits_and_order();
        unmapped_access();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/soc_pkg.sv
rtl/spi_shifter.sv
rtl/spi_regs.sv
rtl/conf_regs.sv
rtl/bus_fabric.sv
rtl/soc_top.sv
verification/soc_tb.sv

// File: Bender.yml
package:
  name: soc_subsystem

sources:
  - rtl/soc_pkg.sv
  - rtl/spi_shifter.sv
  - rtl/spi_regs.sv
  - rtl/conf_regs.sv
  - rtl/bus_fabric.sv
  - rtl/soc_top.sv
  - target: simulation
    files:
      - verification/soc_tb.sv
